// File: src/fp_cast_settings.svh
// --------------------------------------------------
// FP32 <-> INT32 cast unit constants
// Field widths, bias, rounding and status encodings
// --------------------------------------------------
`ifndef FP_CAST_SETTINGS_SVH
`define FP_CAST_SETTINGS_SVH

// FP32 format
`define FP_EXP_BITS 8
`define FP_MAN_BITS 23
`define FP_BIAS     127

`define INT_WIDTH   32  // Integer width, also internal mantissa width
`define EXP_WIDTH   10  // Signed internal exponent

`define RM_RNE      0   // Round to nearest, ties to even
`define RM_RTZ      1   // Round toward zero

`define ST_NV       1   // Invalid
`define ST_NX       0   // Inexact

// Payload widths between stages
`define MID_WIDTH   (1 + `EXP_WIDTH + `INT_WIDTH + 6)
`define OUT_WIDTH   (`INT_WIDTH + 2)
`endif

// File: src/fp_cast_pkg.sv
// --------------------------------------------------
// Cast unit types
// Vector types shared by the datapath blocks
// --------------------------------------------------
`default_nettype none

`include "fp_cast_settings.svh"

package fp_cast_pkg;

  // --------------------------------------------------
  // Data words
  // --------------------------------------------------
  // Raw operand or result, float or integer
  typedef logic [`INT_WIDTH-1:0] operand_t;

  // Unbiased exponent, must hold subnormal range
  typedef logic signed [`EXP_WIDTH-1:0] exp_t;

  // Left-aligned mantissa, leading one in MSB
  typedef logic [`INT_WIDTH-1:0] mant_t;

  // --------------------------------------------------
  // Control and flags
  // --------------------------------------------------
  // NV at ST_NV, NX at ST_NX
  typedef logic [1:0] status_t;

  // RNE or RTZ
  typedef logic rnd_mode_t;

endpackage

`default_nettype wire

// File: src/fp_cast_pipe_stage.sv
// --------------------------------------------------
// Single valid/ready register stage
// Holds one payload, ready passes back combinationally
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fp_cast_pipe_stage #(
  parameter int unsigned WIDTH = 32
) (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  // Upstream side
  input  wire logic             valid_i,
  output logic                  ready_o,
  input  wire logic [WIDTH-1:0] data_i,
  // Downstream side
  output logic                  valid_o,
  input  wire logic             ready_i,
  output logic [WIDTH-1:0]      data_o
);

  logic             valid_q;
  logic [WIDTH-1:0] data_q;

  // Accept when the item ahead moves on or the slot is empty
  assign ready_o = ready_i | ~valid_q;

  // Valid follows upstream whenever we can advance
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;  // Held stable while stalled

endmodule

`default_nettype wire

// File: src/fp_cast_normalize.sv
// --------------------------------------------------
// Cast normalizer
// Classifies the source, left-aligns the mantissa
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fp_cast_settings.svh"

module fp_cast_normalize (
  input  wire fp_cast_pkg::operand_t  operand_i,
  input  wire logic                   f2i_i,      // 1 F2I, 0 I2F
  input  wire logic                   unsigned_i,
  input  wire fp_cast_pkg::rnd_mode_t rnd_mode_i,
  output logic [`MID_WIDTH-1:0]       mid_o
);

  localparam int unsigned LZC_WIDTH = $clog2(`INT_WIDTH);

  // --------------------------------------------------
  // FP32 classification
  // --------------------------------------------------
  logic                    fp_sign;
  logic [`FP_EXP_BITS-1:0] fp_exp_field;
  logic [`FP_MAN_BITS-1:0] fp_man_field;
  logic                    exp_all_zero, exp_all_one, man_zero;
  logic                    fp_is_normal, fp_is_sub, fp_is_inf, fp_is_nan;

  assign fp_sign      = operand_i[`INT_WIDTH-1];
  assign fp_exp_field = operand_i[`FP_MAN_BITS +: `FP_EXP_BITS];
  assign fp_man_field = operand_i[`FP_MAN_BITS-1:0];

  assign exp_all_zero = (fp_exp_field == '0);
  assign exp_all_one  = (fp_exp_field == '1);
  assign man_zero     = (fp_man_field == '0);

  assign fp_is_normal = ~exp_all_zero & ~exp_all_one;  // Hidden bit set
  assign fp_is_sub    = exp_all_zero & ~man_zero;
  assign fp_is_inf    = exp_all_one & man_zero;
  assign fp_is_nan    = exp_all_one & ~man_zero;

  // --------------------------------------------------
  // Integer magnitude
  // --------------------------------------------------
  logic                  int_sign;
  fp_cast_pkg::operand_t int_mag;

  assign int_sign = operand_i[`INT_WIDTH-1] & ~unsigned_i;  // Unsigned never negative
  assign int_mag  = int_sign ? fp_cast_pkg::operand_t'(-operand_i) : operand_i;

  // Mantissa before alignment, FP sits in the low bits
  fp_cast_pkg::mant_t enc_mant;
  assign enc_mant = f2i_i ? fp_cast_pkg::mant_t'({fp_is_normal, fp_man_field}) : int_mag;

  // --------------------------------------------------
  // Leading-zero count
  // --------------------------------------------------
  logic [LZC_WIDTH-1:0] lz_cnt;
  logic                 mant_is_zero;

  always_comb begin : lzc
    lz_cnt = '0;  // Zero input keeps count 0
    // Highest set bit wins, scan upward
    for (int i = 0; i < `INT_WIDTH; i++) begin
      if (enc_mant[i]) begin
        lz_cnt = LZC_WIDTH'(`INT_WIDTH - 1 - i);
      end
    end
  end

  assign mant_is_zero = (enc_mant == '0);

  // --------------------------------------------------
  // Alignment and exponent
  // --------------------------------------------------
  fp_cast_pkg::mant_t norm_mant;
  fp_cast_pkg::exp_t  fp_input_exp, int_input_exp, input_exp;
  logic               input_sign;

  assign norm_mant = enc_mant << lz_cnt;  // Leading one to MSB

  // Unbias, subnormals use 1-bias, undo the low placement and the shift
  assign fp_input_exp = fp_cast_pkg::exp_t'(fp_exp_field)
                      + fp_cast_pkg::exp_t'(fp_is_sub)
                      - fp_cast_pkg::exp_t'(`FP_BIAS)
                      - fp_cast_pkg::exp_t'(lz_cnt)
                      + fp_cast_pkg::exp_t'(`INT_WIDTH - 1 - `FP_MAN_BITS);

  // Integer weight of the leading one
  assign int_input_exp = fp_cast_pkg::exp_t'(`INT_WIDTH - 1) - fp_cast_pkg::exp_t'(lz_cnt);

  assign input_exp  = f2i_i ? fp_input_exp : int_input_exp;
  assign input_sign = f2i_i ? fp_sign : int_sign;

  // Pack for stage 1, NaN and inf only exist for float sources
  assign mid_o = {input_sign, input_exp, norm_mant,
                  f2i_i & fp_is_nan, f2i_i & fp_is_inf, mant_is_zero,
                  f2i_i, unsigned_i, rnd_mode_i};

endmodule

`default_nettype wire

// File: src/fp_cast_round.sv
// --------------------------------------------------
// Cast rounder
// Shifts to target position, rounds, applies specials
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fp_cast_settings.svh"

module fp_cast_round (
  input  wire logic [`MID_WIDTH-1:0] mid_i,
  output fp_cast_pkg::operand_t      result_o,
  output fp_cast_pkg::status_t       status_o
);

  localparam int unsigned SHIFT_WIDTH = 2 * `INT_WIDTH + 1;  // Mantissa, int bits, round bit
  localparam int unsigned SHAMT_WIDTH = $clog2(SHIFT_WIDTH);

  // --------------------------------------------------
  // Unpack stage 1 payload
  // --------------------------------------------------
  logic                   sign_q;
  fp_cast_pkg::exp_t      exp_q;
  fp_cast_pkg::mant_t     mant_q;
  logic                   is_nan_q, is_inf_q, mant_zero_q;
  logic                   f2i_q, unsigned_q;
  fp_cast_pkg::rnd_mode_t rnd_mode_q;

  assign {sign_q, exp_q, mant_q, is_nan_q, is_inf_q, mant_zero_q,
          f2i_q, unsigned_q, rnd_mode_q} = mid_i;

  // --------------------------------------------------
  // Shift to destination position
  // --------------------------------------------------
  logic [SHAMT_WIDTH-1:0] shamt;
  logic                   of_before_round;
  logic                   is_int_min;

  // -2^31 is the one value at exponent 31 that still fits signed
  assign is_int_min = sign_q & (mant_q == {1'b1, {(`INT_WIDTH-1){1'b0}}});

  always_comb begin : shift_amount
    shamt           = SHAMT_WIDTH'(`INT_WIDTH - 1 - `FP_MAN_BITS);  // I2F keeps 24 bits
    of_before_round = 1'b0;
    if (f2i_q) begin
      if (exp_q > fp_cast_pkg::exp_t'(`INT_WIDTH - 1)) begin
        shamt           = '0;    // Too large for any int
        of_before_round = 1'b1;
      end else if (exp_q < fp_cast_pkg::exp_t'(-1)) begin
        shamt = SHAMT_WIDTH'(`INT_WIDTH + 1);  // Below 0.5, all to sticky
      end else begin
        shamt = SHAMT_WIDTH'(`INT_WIDTH - 1 - exp_q);
        // Exponent 31 overflows signed except for the minimum
        if (exp_q == fp_cast_pkg::exp_t'(`INT_WIDTH - 1)) begin
          of_before_round = ~unsigned_q & ~is_int_min;
        end
      end
    end
  end

  logic [SHIFT_WIDTH-1:0] preshift_mant, dest_mant;
  fp_cast_pkg::operand_t  final_int;
  logic                   round_bit, sticky_bit;

  assign preshift_mant = {mant_q, {(`INT_WIDTH+1){1'b0}}};  // Mantissa at the top
  assign dest_mant     = preshift_mant >> shamt;

  assign {final_int, round_bit} = dest_mant[SHIFT_WIDTH-1 -: `INT_WIDTH+1];
  assign sticky_bit             = |dest_mant[`INT_WIDTH-1:0];

  // --------------------------------------------------
  // Rounding
  // --------------------------------------------------
  logic                  round_up;
  fp_cast_pkg::operand_t rounded_abs;

  always_comb begin : round_decision
    case (rnd_mode_q)
      1'(`RM_RNE): round_up = round_bit & (sticky_bit | final_int[0]);  // Ties to even
      1'(`RM_RTZ): round_up = 1'b0;  // Truncate
      default:     round_up = 1'b0;
    endcase
  end

  assign rounded_abs = final_int + fp_cast_pkg::operand_t'(round_up);  // No wrap possible

  // --------------------------------------------------
  // I2F result
  // --------------------------------------------------
  fp_cast_pkg::exp_t     fp_biased_exp;
  fp_cast_pkg::operand_t fp_result;

  // Carry out of 24 bits bumps exponent, mantissa field already zero then
  assign fp_biased_exp = exp_q + fp_cast_pkg::exp_t'(`FP_BIAS)
                       + fp_cast_pkg::exp_t'(rounded_abs[`FP_MAN_BITS+1]);

  assign fp_result = mant_zero_q ? '0  // Integer zero gives +0
                   : {sign_q, fp_biased_exp[`FP_EXP_BITS-1:0], rounded_abs[`FP_MAN_BITS-1:0]};

  // --------------------------------------------------
  // F2I result and specials
  // --------------------------------------------------
  fp_cast_pkg::operand_t rounded_int;
  fp_cast_pkg::operand_t int_special_res;
  logic                  int_is_special;

  assign rounded_int = sign_q ? fp_cast_pkg::operand_t'(-rounded_abs) : rounded_abs;

  // NaN, inf, overflow, or negative nonzero into unsigned
  assign int_is_special = is_nan_q | is_inf_q | of_before_round
                        | (sign_q & unsigned_q & (rounded_abs != '0));

  always_comb begin : int_special
    int_special_res = {unsigned_q, {(`INT_WIDTH-1){1'b1}}};  // Positive max
    if (sign_q && !is_nan_q) begin
      int_special_res = ~int_special_res;  // Signed min or 0
    end
  end

  // --------------------------------------------------
  // Output select
  // --------------------------------------------------
  always_comb begin : out_select
    status_o = '0;
    if (f2i_q && int_is_special) begin
      result_o           = int_special_res;
      status_o[`ST_NV]   = 1'b1;
    end else begin
      result_o           = f2i_q ? rounded_int : fp_result;
      status_o[`ST_NX]   = round_bit | sticky_bit;  // Any dropped bit
    end
  end

endmodule

`default_nettype wire

// File: src/fp_cast_top.sv
// --------------------------------------------------
// FP32 <-> INT32 cast unit
// Normalize, register, round, register
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fp_cast_settings.svh"

module fp_cast_top (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  // Input side
  input  wire fp_cast_pkg::operand_t  operand_i,
  input  wire logic                   f2i_i,
  input  wire logic                   unsigned_i,
  input  wire fp_cast_pkg::rnd_mode_t rnd_mode_i,
  input  wire logic                   in_valid_i,
  output logic                        in_ready_o,
  // Output side
  output fp_cast_pkg::operand_t       result_o,
  output fp_cast_pkg::status_t        status_o,
  output logic                        out_valid_o,
  input  wire logic                   out_ready_i,
  output logic                        busy_o  // Item in flight
);

  logic [`MID_WIDTH-1:0] mid_d, mid_q;
  logic                  mid_valid;
  logic                  out_stage_ready;
  logic [`OUT_WIDTH-1:0] out_d, out_q;
  fp_cast_pkg::operand_t round_result;
  fp_cast_pkg::status_t  round_status;

  // --------------------------------------------------
  // Stage 1, after normalization
  // --------------------------------------------------
  fp_cast_normalize u_normalize (
    .operand_i  ( operand_i  ),
    .f2i_i      ( f2i_i      ),
    .unsigned_i ( unsigned_i ),
    .rnd_mode_i ( rnd_mode_i ),
    .mid_o      ( mid_d      )
  );

  fp_cast_pipe_stage #(.WIDTH(`MID_WIDTH)) u_mid_stage (
    .clk_i    ( clk_i           ),
    .arst_n_i ( arst_n_i        ),
    .valid_i  ( in_valid_i      ),
    .ready_o  ( in_ready_o      ),
    .data_i   ( mid_d           ),
    .valid_o  ( mid_valid       ),
    .ready_i  ( out_stage_ready ),  // Backpressure from stage 2
    .data_o   ( mid_q           )
  );

  // --------------------------------------------------
  // Stage 2, after rounding
  // --------------------------------------------------
  fp_cast_round u_round (
    .mid_i    ( mid_q        ),
    .result_o ( round_result ),
    .status_o ( round_status )
  );

  assign out_d = {round_result, round_status};

  fp_cast_pipe_stage #(.WIDTH(`OUT_WIDTH)) u_out_stage (
    .clk_i    ( clk_i           ),
    .arst_n_i ( arst_n_i        ),
    .valid_i  ( mid_valid       ),
    .ready_o  ( out_stage_ready ),
    .data_i   ( out_d           ),
    .valid_o  ( out_valid_o     ),
    .ready_i  ( out_ready_i     ),
    .data_o   ( out_q           )
  );

  assign {result_o, status_o} = out_q;
  assign busy_o               = mid_valid | out_valid_o;

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
// --------------------------------------------------
// Testbench clock and reset source
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 100,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;  // Asserted from time zero
    // Release a quarter period after a falling edge, clear of both edges
    #(PERIOD_NS * RST_CYCLES + PERIOD_NS / 4) arst_n_o = 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: sim/tb_fp_cast.sv
// --------------------------------------------------
// FP32 <-> INT32 cast unit testbench
// Corner and random items, reference model, scoreboard
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fp_cast_settings.svh"

module tb_fp_cast;

  localparam logic [31:0] LFSR_SEED  = 32'hd8f0_8268;
  localparam int unsigned TIMEOUT    = 1000;  // Cycles allowed per wait
  localparam int unsigned NUM_RANDOM = 400;
  localparam int unsigned NUM_CORNER = 20;

  logic                   clk_i;
  logic                   arst_n_i;
  fp_cast_pkg::operand_t  operand_i;
  logic                   f2i_i, unsigned_i, in_valid_i, in_ready_o;
  fp_cast_pkg::rnd_mode_t rnd_mode_i;
  fp_cast_pkg::operand_t  result_o;
  fp_cast_pkg::status_t   status_o;
  logic                   out_valid_o, out_ready_i, busy_o;

  logic [31:0] lfsr_state;
  logic        random_ready;            // Back-pressure on or off
  logic [33:0] expect_q [$];            // {result, status} per item in flight
  logic        stall_prev = 1'b0;
  logic [33:0] held_prev;
  int unsigned n_in = 0;
  int unsigned n_out = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    ( clk_i    ),
    .arst_n_o ( arst_n_i )
  );

  fp_cast_top u_dut (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .operand_i   ( operand_i   ),
    .f2i_i       ( f2i_i       ),
    .unsigned_i  ( unsigned_i  ),
    .rnd_mode_i  ( rnd_mode_i  ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  // --------------------------------------------------
  // Error exits
  // --------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [33:0] exp_v,
                                 input logic [33:0] act_v);
    stop_on_error($sformatf("mismatch %s: expected 0x%h, actual 0x%h", name, exp_v, act_v));
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [33:0] pack_result(input logic [31:0] res, input logic nv,
                                              input logic nx);
    fp_cast_pkg::status_t st;
    st         = '0;
    st[`ST_NV] = nv;
    st[`ST_NX] = nx;
    return {res, st};
  endfunction

  // Integer to float keeping 24 significant bits
  function automatic logic [33:0] ref_i2f(input logic [31:0] op, input logic uns,
                                          input logic rm);
    logic        neg, up;
    logic [63:0] mag, kept, rem, half;
    int          msb, sh, i;
    neg = op[31] && !uns;
    mag = {32'd0, neg ? ~op + 32'd1 : op};
    if (mag == 0) return pack_result(32'd0, 1'b0, 1'b0);  // +0 always
    msb = 0;
    for (i = 0; i < 32; i++) begin
      if (mag[i]) msb = i;
    end
    sh   = (msb > `FP_MAN_BITS) ? msb - `FP_MAN_BITS : 0;
    kept = mag >> sh;
    rem  = mag - (kept << sh);                       // Dropped bits
    kept = kept << (`FP_MAN_BITS + sh - msb);        // Leading one to bit 23
    half = (sh > 0) ? (64'd1 << (sh - 1)) : 64'd0;
    up   = (rm == 1'(`RM_RNE)) && (sh > 0) && ((rem > half) || (rem == half && kept[0]));
    kept = kept + 64'(up);
    if (kept[`FP_MAN_BITS+1]) begin                  // Rounded up to next power of two
      kept = kept >> 1;
      msb++;
    end
    return pack_result({neg, 8'(msb + `FP_BIAS), kept[`FP_MAN_BITS-1:0]}, 1'b0, rem != 0);
  endfunction

  // Float to integer with saturation
  function automatic logic [33:0] ref_f2i(input logic [31:0] op, input logic uns,
                                          input logic rm);
    logic        neg, up;
    logic [7:0]  e;
    logic [63:0] sig, mag, rem, half, lim;
    int          pow;
    neg = op[31];
    e   = op[30:23];
    if (e == 8'hff && (op[22:0] != 0 || !neg))       // NaN or +inf
      return pack_result(uns ? 32'hffff_ffff : 32'h7fff_ffff, 1'b1, 1'b0);
    if (e == 8'hff)                                  // -inf
      return pack_result(uns ? 32'h0 : 32'h8000_0000, 1'b1, 1'b0);
    sig = {40'd0, e != 0, op[22:0]};
    pow = ((e == 0) ? 1 : int'(e)) - `FP_BIAS - `FP_MAN_BITS;  // Weight of sig LSB
    rem = '0;
    up  = 1'b0;
    if (pow > 39) begin
      mag = 64'd1 << 40;                             // Far beyond any limit
    end else if (pow >= 0) begin
      mag = sig << pow;
    end else if (pow < -40) begin
      mag = '0;                                      // Too small to ever round up
      rem = sig;
    end else begin
      mag  = sig >> (-pow);
      rem  = sig - (mag << (-pow));
      half = 64'd1 << (-pow - 1);
      up   = (rm == 1'(`RM_RNE)) && ((rem > half) || (rem == half && mag[0]));
    end
    mag = mag + 64'(up);
    lim = neg ? 64'h8000_0000 : (uns ? 64'hffff_ffff : 64'h7fff_ffff);
    if (neg && uns && mag != 0) return pack_result(32'h0, 1'b1, 1'b0);
    if (mag > lim) return pack_result(neg ? 32'h8000_0000 : lim[31:0], 1'b1, 1'b0);
    return pack_result(neg ? ~mag[31:0] + 32'd1 : mag[31:0], 1'b0, rem != 0);
  endfunction

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    int unsigned k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Bit 32 set means F2I
  function automatic logic [32:0] corner_item(input int idx);
    case (idx)
      0:       corner_item = {1'b0, 32'h0000_0000};  // Zero
      1:       corner_item = {1'b0, 32'hffff_ffff};  // -1 or max unsigned
      2:       corner_item = {1'b0, 32'h0100_0001};  // Tie stays even
      3:       corner_item = {1'b0, 32'h0100_0003};  // Tie rounds up to even
      4:       corner_item = {1'b0, 32'h7fff_ffff};
      5:       corner_item = {1'b0, 32'h8000_0000};  // Int minimum
      6:       corner_item = {1'b0, 32'h00ff_ffff};  // Exact in 24 bits
      7:       corner_item = {1'b1, 32'h8000_0000};  // -0
      8:       corner_item = {1'b1, 32'h0000_0001};  // Smallest subnormal
      9:       corner_item = {1'b1, 32'h3f00_0000};  // 0.5
      10:      corner_item = {1'b1, 32'h3fc0_0000};  // 1.5
      11:      corner_item = {1'b1, 32'h4020_0000};  // 2.5
      12:      corner_item = {1'b1, 32'hbf40_0000};  // -0.75
      13:      corner_item = {1'b1, 32'h7fc0_0000};  // NaN
      14:      corner_item = {1'b1, 32'h7f80_0000};  // +inf
      15:      corner_item = {1'b1, 32'hff80_0000};  // -inf
      16:      corner_item = {1'b1, 32'h4f00_0000};  // 2^31
      17:      corner_item = {1'b1, 32'hcf00_0000};  // -2^31
      18:      corner_item = {1'b1, 32'h4f80_0000};  // 2^32
      default: corner_item = {1'b1, 32'hbf80_0000};  // -1.0
    endcase
  endfunction

  task automatic random_item(output fp_cast_pkg::operand_t op, output logic f2i,
                             output logic uns, output logic rm);
    logic [31:0] bits;
    take_bits(32, bits);
    op = bits;
    take_bits(10, bits);
    {f2i, uns, rm} = bits[9:7];
    if (bits[6] && f2i) begin
      op[30:23] = 8'(118 + int'(bits[5:0]) % 43);  // Exponents around the int range
    end else if (bits[6]) begin
      op = op >> bits[4:0];  // Smaller integers
    end
  endtask

  task automatic drive_ready();
    logic [31:0] bits;
    if (random_ready) begin
      take_bits(2, bits);
      out_ready_i <= |bits[1:0];  // High three times in four
    end else begin
      out_ready_i <= 1'b1;
    end
  endtask

  // Presents one item and holds it until the DUT takes it
  task automatic send_item(input fp_cast_pkg::operand_t op, input logic f2i,
                           input logic uns, input logic rm);
    int unsigned waited;
    @(posedge clk_i);
    operand_i  <= op;
    f2i_i      <= f2i;
    unsigned_i <= uns;
    rnd_mode_i <= rm;
    in_valid_i <= 1'b1;
    drive_ready();
    waited = 0;
    @(negedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("timeout waiting for in_ready_o to accept an item");
      @(posedge clk_i);
      drive_ready();
      @(negedge clk_i);
    end
  endtask

  task automatic wait_idle();
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (busy_o) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("timeout waiting for the pipeline to drain");
      @(posedge clk_i);
      drive_ready();
      @(negedge clk_i);
    end
  endtask

  // Back-to-back items into an empty pipeline with output always ready
  task automatic run_back_to_back(input int n);
    fp_cast_pkg::operand_t op;
    logic                  f2i, uns, rm;
    int                    c;
    wait_idle();
    for (c = 0; c <= n + 1; c++) begin
      @(posedge clk_i);
      out_ready_i <= 1'b1;
      if (c < n) begin
        random_item(op, f2i, uns, rm);
        operand_i  <= op;
        f2i_i      <= f2i;
        unsigned_i <= uns;
        rnd_mode_i <= rm;
        in_valid_i <= 1'b1;
      end else begin
        in_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      if (c == 1) begin
        assert (!out_valid_o) else stop_on_error("result valid one cycle early");
      end
      if (c >= 2) begin
        assert (out_valid_o) else stop_on_error("result missing at its output cycle");
      end
    end
  endtask

  // --------------------------------------------------
  // Scoreboard sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk_i) begin : scoreboard
    if (arst_n_i !== 1'b1) begin
      assert (!out_valid_o && !busy_o && in_ready_o)
        else stop_on_error("handshake outputs not in reset state during reset");
      stall_prev = 1'b0;
    end else begin
      assert (busy_o == (expect_q.size() != 0))
        else report_mismatch("busy_o", 34'(expect_q.size() != 0), 34'(busy_o));
      if (stall_prev) begin  // No transfer on the last edge
        assert (out_valid_o) else stop_on_error("out_valid_o dropped before the transfer");
        assert ({result_o, status_o} == held_prev)
          else report_mismatch("result_o/status_o while stalled", held_prev,
                               {result_o, status_o});
      end
      if (out_valid_o) begin
        if (expect_q.size() == 0) stop_on_error("out_valid_o high with no item in flight");
        assert (result_o == expect_q[0][33:2])
          else report_mismatch("result_o", 34'(expect_q[0][33:2]), 34'(result_o));
        assert (status_o == expect_q[0][1:0])
          else report_mismatch("status_o", 34'(expect_q[0][1:0]), 34'(status_o));
        if (out_ready_i) begin
          void'(expect_q.pop_front());
          n_out++;
        end
      end
      stall_prev = out_valid_o && !out_ready_i;
      held_prev  = {result_o, status_o};
      if (in_valid_i && in_ready_o) begin  // Taken on the coming edge
        expect_q.push_back(f2i_i ? ref_f2i(operand_i, unsigned_i, rnd_mode_i)
                                 : ref_i2f(operand_i, unsigned_i, rnd_mode_i));
        n_in++;
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : stimulus
    fp_cast_pkg::operand_t op;
    logic                  f2i, uns, rm;
    logic [32:0]           corner;
    int unsigned           waited;
    int                    i, m;
    lfsr_state   = LFSR_SEED;
    random_ready = 1'b0;
    operand_i   <= '0;
    f2i_i       <= 1'b0;
    unsigned_i  <= 1'b0;
    rnd_mode_i  <= 1'b0;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
    waited = 0;
    while (arst_n_i !== 1'b1) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) stop_on_error("timeout waiting for reset release");
    end
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && !busy_o)
      else stop_on_error("handshake outputs not idle after reset release");

    run_back_to_back(1);  // Single item latency
    run_back_to_back(4);  // One result per cycle

    random_ready = 1'b1;
    for (i = 0; i < NUM_CORNER; i++) begin
      corner = corner_item(i);
      for (m = 0; m < 4; m++) begin  // Signedness and rounding mode
        send_item(corner[31:0], corner[32], m[1], m[0]);
      end
    end
    for (i = 0; i < NUM_RANDOM; i++) begin
      random_item(op, f2i, uns, rm);
      send_item(op, f2i, uns, rm);
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    drive_ready();
    wait_idle();

    if (expect_q.size() == 0 && n_out == n_in && n_in == 5 + 4 * NUM_CORNER + NUM_RANDOM) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_error($sformatf("item count wrong, %0d accepted and %0d returned", n_in, n_out));
    end
  end

endmodule

`default_nettype wire

// File: fp_cast.f
+incdir+src
src/fp_cast_pkg.sv
src/fp_cast_pipe_stage.sv
src/fp_cast_normalize.sv
src/fp_cast_round.sv
src/fp_cast_top.sv
sim/tb_clk_gen.sv
sim/tb_fp_cast.sv

// File: Bender.yml
package:
  name: fp_cast

sources:
  - include_dirs:
      - src
    files:
      - src/fp_cast_pkg.sv
      - src/fp_cast_pipe_stage.sv
      - src/fp_cast_normalize.sv
      - src/fp_cast_round.sv
      - src/fp_cast_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_fp_cast.sv
